// ==== compile.f ====
+incdir+src
src/core_pkg.sv
src/instr_intake.sv
src/reg_file.sv
src/exec_pipe.sv
src/commit_port.sv
src/alu_core_top.sv
testbench/tb_alu_core.sv

// ==== src/alu_core_top.sv ====
`timescale 1ns/1ps
`include "core_consts.svh"

module alu_core_top (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  in_valid_i,
    input  core_pkg::instr_word_u in_word_i,
    output logic                  in_credit_o,
    output logic                  out_valid_o,
    output core_pkg::commit_rec_t out_rec_o,
    input  logic                  out_credit_i
);
    import core_pkg::*;

    logic         word_valid;
    instr_word_u  word;
    logic         word_take;
    logic         rec_valid;
    commit_rec_t  rec;
    logic         commit_room;

    instr_intake #(.DEPTH(`CORE_INTAKE_DEPTH)) u_intake (
        .clk          (clk),
        .resetn       (resetn),
        .in_valid_i   (in_valid_i),
        .in_word_i    (in_word_i),
        .in_credit_o  (in_credit_o),
        .word_valid_o (word_valid),
        .word_o       (word),
        .word_take_i  (word_take)
    );

    exec_pipe u_exec (
        .clk           (clk),
        .resetn        (resetn),
        .word_valid_i  (word_valid),
        .word_i        (word),
        .word_take_o   (word_take),
        .commit_room_i (commit_room),
        .rec_valid_o   (rec_valid),
        .rec_o         (rec)
    );

    commit_port #(
        .DEPTH   (`CORE_COMMIT_DEPTH),
        .CREDITS (`CORE_OUT_CREDITS)
    ) u_commit (
        .clk           (clk),
        .resetn        (resetn),
        .rec_valid_i   (rec_valid),
        .rec_i         (rec),
        .commit_room_o (commit_room),
        .out_valid_o   (out_valid_o),
        .out_rec_o     (out_rec_o),
        .out_credit_i  (out_credit_i)
    );

endmodule

// ==== src/commit_port.sv ====
`timescale 1ns/1ps
`include "core_consts.svh"

module commit_port #(
    parameter int DEPTH   = `CORE_COMMIT_DEPTH,
    parameter int CREDITS = `CORE_OUT_CREDITS
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  rec_valid_i,
    input  core_pkg::commit_rec_t rec_i,
    output logic                  commit_room_o,
    output logic                  out_valid_o,
    output core_pkg::commit_rec_t out_rec_o,
    input  logic                  out_credit_i
);
    import core_pkg::*;

    localparam int PW  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW  = $clog2(DEPTH + 1);
    localparam int CRW = $clog2(CREDITS + 1) + 1;

    commit_rec_t     rec_mem [DEPTH];
    logic [PW-1:0]   wr_ptr;
    logic [PW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic [CRW-1:0]  credit_cnt;
    logic            pop;

    assign commit_room_o = (count != CW'(DEPTH));
    // head goes out only with a credit in hand
    assign out_valid_o   = (count != '0) && (credit_cnt != '0);
    assign out_rec_o     = rec_mem[rd_ptr];
    assign pop           = out_valid_o;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_cnt <= CRW'(CREDITS);
        end else begin
            if (rec_valid_i) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (rec_valid_i && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !rec_valid_i) begin
                count <= count - 1'b1;
            end
            // spend on emit, regain on receiver return
            if (pop && !out_credit_i) begin
                credit_cnt <= credit_cnt - 1'b1;
            end else if (out_credit_i && !pop) begin
                credit_cnt <= credit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rec_valid_i) begin
            rec_mem[wr_ptr] <= rec_i;
        end
    end

    a_credit_bound: assert property (
        @(posedge clk) disable iff (!resetn) credit_cnt <= CRW'(CREDITS)
    ) else $error("commit_port: receiver returned more credits than granted");

    a_no_push_full: assert property (
        @(posedge clk) disable iff (!resetn) rec_valid_i |-> commit_room_o
    ) else $error("commit_port: record pushed into a full queue");

endmodule

// ==== src/core_consts.svh ====
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// datapath and register file
`define CORE_DATA_W         32
`define CORE_REG_AW         5
`define CORE_NUM_REGS       32

// buffering and flow control
`define CORE_INTAKE_DEPTH   4
`define CORE_OUT_CREDITS    4
`define CORE_COMMIT_DEPTH   4

// major opcodes
`define CORE_OP_RTYPE       6'h00
`define CORE_OP_ADDIU       6'h09
`define CORE_OP_ORI         6'h0d
`define CORE_OP_LUI         6'h0f

// function codes, R-format only
`define CORE_FN_ADDU        6'h21
`define CORE_FN_SUBU        6'h23
`define CORE_FN_AND         6'h24
`define CORE_FN_OR          6'h25
`define CORE_FN_XOR         6'h26
`define CORE_FN_SLT         6'h2a

`endif

// ==== src/core_pkg.sv ====
`include "core_consts.svh"

package core_pkg;

    //////////////////////////////////////////////////
    // instruction word, two decode views
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [5:0]               opcode;
        logic [`CORE_REG_AW-1:0]  rs;
        logic [`CORE_REG_AW-1:0]  rt;
        logic [`CORE_REG_AW-1:0]  rd;
        logic [4:0]               shamt;
        logic [5:0]               funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]               opcode;
        logic [`CORE_REG_AW-1:0]  rs;
        logic [`CORE_REG_AW-1:0]  rt;
        logic [15:0]              imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_word_u;

    //////////////////////////////////////////////////
    // records between blocks
    //////////////////////////////////////////////////

    // register file write, also the forward source
    typedef struct packed {
        logic                     wen;
        logic [`CORE_REG_AW-1:0]  addr;
        logic [`CORE_DATA_W-1:0]  data;
    } reg_write_t;

    // one committed instruction
    typedef struct packed {
        logic                     illegal;
        logic                     wen;
        logic [`CORE_REG_AW-1:0]  wnum;
        logic [`CORE_DATA_W-1:0]  wdata;
    } commit_rec_t;

endpackage

// ==== src/exec_pipe.sv ====
`timescale 1ns/1ps
`include "core_consts.svh"

module exec_pipe (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  word_valid_i,
    input  core_pkg::instr_word_u word_i,
    output logic                  word_take_o,
    input  logic                  commit_room_i,
    output logic                  rec_valid_o,
    output core_pkg::commit_rec_t rec_o
);
    import core_pkg::*;

    // read stage
    logic                     rd_valid;
    instr_word_u              rd_word;
    logic [`CORE_REG_AW-1:0]  rs_addr;
    logic [`CORE_REG_AW-1:0]  rt_addr;
    logic [`CORE_DATA_W-1:0]  rs_rf;
    logic [`CORE_DATA_W-1:0]  rt_rf;
    logic [`CORE_DATA_W-1:0]  rs_val;
    logic [`CORE_DATA_W-1:0]  rt_val;
    logic [`CORE_DATA_W-1:0]  op_b;
    logic                     legal;
    logic                     dec_wen;
    logic [`CORE_REG_AW-1:0]  dec_wnum;
    // execute stage
    logic                     ex_valid;
    instr_word_u              ex_word;
    logic [`CORE_DATA_W-1:0]  ex_a;
    logic [`CORE_DATA_W-1:0]  ex_b;
    logic                     ex_illegal;
    logic                     ex_wen;
    logic [`CORE_REG_AW-1:0]  ex_wnum;
    logic [`CORE_DATA_W-1:0]  alu_res;
    reg_write_t               ex_pend;
    reg_write_t               rf_wr;
    logic                     ex_adv;
    logic                     rd_adv;

    // execute only leaves when the commit queue has a slot
    assign ex_adv      = !ex_valid || commit_room_i;
    assign rd_adv      = !rd_valid || ex_adv;
    assign word_take_o = rd_adv;

    //////////////////////////////////////////////////
    // read stage, decode and operand fetch
    //////////////////////////////////////////////////

    assign rs_addr = rd_word.r_fmt.rs;
    assign rt_addr = rd_word.r_fmt.rt;

    reg_file u_reg_file (
        .clk       (clk),
        .resetn    (resetn),
        .rs_addr_i (rs_addr),
        .rt_addr_i (rt_addr),
        .rs_data_o (rs_rf),
        .rt_data_o (rt_rf),
        .wr_i      (rf_wr)
    );

    // forward from the pending execute result
    assign rs_val = (ex_pend.wen && ex_pend.addr == rs_addr && rs_addr != '0) ?
                    ex_pend.data : rs_rf;
    assign rt_val = (ex_pend.wen && ex_pend.addr == rt_addr && rt_addr != '0) ?
                    ex_pend.data : rt_rf;

    always_comb begin
        legal    = 1'b1;
        dec_wnum = rd_word.i_fmt.rt;
        op_b     = rt_val;
        case (rd_word.r_fmt.opcode)
            `CORE_OP_RTYPE: begin
                dec_wnum = rd_word.r_fmt.rd;
                case (rd_word.r_fmt.funct)
                    `CORE_FN_ADDU, `CORE_FN_SUBU, `CORE_FN_AND,
                    `CORE_FN_OR, `CORE_FN_XOR, `CORE_FN_SLT: legal = 1'b1;
                    default: legal = 1'b0;
                endcase
            end
            `CORE_OP_ADDIU: op_b = {{16{rd_word.i_fmt.imm[15]}}, rd_word.i_fmt.imm};
            `CORE_OP_ORI:   op_b = {16'b0, rd_word.i_fmt.imm};
            `CORE_OP_LUI:   op_b = {rd_word.i_fmt.imm, 16'b0};
            default:        legal = 1'b0;
        endcase
        dec_wen = legal && (dec_wnum != '0);
    end

    //////////////////////////////////////////////////
    // execute stage
    //////////////////////////////////////////////////

    always_comb begin
        alu_res = '0;
        case (ex_word.r_fmt.opcode)
            `CORE_OP_RTYPE: begin
                case (ex_word.r_fmt.funct)
                    `CORE_FN_ADDU: alu_res = ex_a + ex_b;
                    `CORE_FN_SUBU: alu_res = ex_a - ex_b;
                    `CORE_FN_AND:  alu_res = ex_a & ex_b;
                    `CORE_FN_OR:   alu_res = ex_a | ex_b;
                    `CORE_FN_XOR:  alu_res = ex_a ^ ex_b;
                    `CORE_FN_SLT:  alu_res = {31'b0, $signed(ex_a) < $signed(ex_b)};
                    default:       alu_res = '0;
                endcase
            end
            `CORE_OP_ADDIU: alu_res = ex_a + ex_b;
            `CORE_OP_ORI:   alu_res = ex_a | ex_b;
            `CORE_OP_LUI:   alu_res = ex_b;
            default:        alu_res = '0;
        endcase
    end

    assign ex_pend.wen  = ex_valid && ex_wen;
    assign ex_pend.addr = ex_wnum;
    assign ex_pend.data = alu_res;

    // write lands on the same edge as the commit push
    assign rf_wr.wen  = ex_pend.wen && commit_room_i;
    assign rf_wr.addr = ex_pend.addr;
    assign rf_wr.data = ex_pend.data;

    assign rec_valid_o   = ex_valid && commit_room_i;
    assign rec_o.illegal = ex_illegal;
    assign rec_o.wen     = ex_wen;
    assign rec_o.wnum    = ex_wnum;
    assign rec_o.wdata   = ex_wen ? alu_res : '0;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_valid <= 1'b0;
            ex_valid <= 1'b0;
        end else begin
            if (rd_adv) begin
                rd_valid <= word_valid_i;
            end
            if (ex_adv) begin
                ex_valid <= rd_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_adv && word_valid_i) begin
            rd_word <= word_i;
        end
        if (ex_adv && rd_valid) begin
            ex_word    <= rd_word;
            ex_a       <= rs_val;
            ex_b       <= op_b;
            ex_illegal <= !legal;
            ex_wen     <= dec_wen;
            ex_wnum    <= dec_wnum;
        end
    end

endmodule

// ==== src/instr_intake.sv ====
`timescale 1ns/1ps
`include "core_consts.svh"

module instr_intake #(
    parameter int DEPTH = `CORE_INTAKE_DEPTH
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  in_valid_i,
    input  core_pkg::instr_word_u in_word_i,
    output logic                  in_credit_o,
    output logic                  word_valid_o,
    output core_pkg::instr_word_u word_o,
    input  logic                  word_take_i
);
    import core_pkg::*;

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    instr_word_u     fifo_mem [DEPTH];
    logic [PW-1:0]   wr_ptr;
    logic [PW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            fifo_full;
    logic            push;
    logic            pop;

    assign fifo_full    = (count == CW'(DEPTH));
    assign push         = in_valid_i && !fifo_full;
    assign word_valid_o = (count != '0);
    assign word_o       = fifo_mem[rd_ptr];
    assign pop          = word_valid_o && word_take_i;

    // one credit back per word handed to the pipe
    assign in_credit_o  = pop;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= in_word_i;
        end
    end

    // sender spent a credit it did not hold
    a_no_credit_overrun: assert property (
        @(posedge clk) disable iff (!resetn) in_valid_i |-> !fifo_full
    ) else $error("intake: word arrived while FIFO full");

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps
`include "core_consts.svh"

module reg_file (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic [`CORE_REG_AW-1:0]  rs_addr_i,
    input  logic [`CORE_REG_AW-1:0]  rt_addr_i,
    output logic [`CORE_DATA_W-1:0]  rs_data_o,
    output logic [`CORE_DATA_W-1:0]  rt_data_o,
    input  core_pkg::reg_write_t     wr_i
);

    logic [`CORE_DATA_W-1:0] regs [`CORE_NUM_REGS];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.wen && wr_i.addr != '0) begin
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    // r0 is hardwired, same-cycle write is passed through
    always_comb begin
        if (rs_addr_i == '0) begin
            rs_data_o = '0;
        end else if (wr_i.wen && wr_i.addr == rs_addr_i) begin
            rs_data_o = wr_i.data;
        end else begin
            rs_data_o = regs[rs_addr_i];
        end
        if (rt_addr_i == '0) begin
            rt_data_o = '0;
        end else if (wr_i.wen && wr_i.addr == rt_addr_i) begin
            rt_data_o = wr_i.data;
        end else begin
            rt_data_o = regs[rt_addr_i];
        end
    end

    // the pipe must drop r0 writes before they get here
    a_no_r0_write: assert property (
        @(posedge clk) disable iff (!resetn) wr_i.wen |-> wr_i.addr != '0
    ) else $error("reg_file: write enable for r0");

endmodule

// ==== testbench/alu_core_vectors.txt ====
// columns: instruction word, expected illegal, wen, wnum, wdata (all hex)
// one instruction per line, in program order
3C011234 0 1 01 12340000 // lui   r1, 0x1234
34215678 0 1 01 12345678 // ori   r1, r1, 0x5678
2402FFFF 0 1 02 FFFFFFFF // addiu r2, r0, -1
24030005 0 1 03 00000005 // addiu r3, r0, 5
00232021 0 1 04 1234567D // addu  r4, r1, r3
00622823 0 1 05 00000006 // subu  r5, r3, r2
00223024 0 1 06 12345678 // and   r6, r1, r2
00653825 0 1 07 00000007 // or    r7, r3, r5
00244026 0 1 08 00000005 // xor   r8, r1, r4
0043482A 0 1 09 00000001 // slt   r9, r2, r3
0062502A 0 1 0A 00000000 // slt   r10, r3, r2
24200100 0 0 00 00000000 // addiu r0, r1, 0x100
00035821 0 1 0B 00000005 // addu  r11, r0, r3
8C220004 1 0 02 00000000 // undefined opcode
00231000 1 0 02 00000000 // undefined function
00406021 0 1 0C FFFFFFFF // addu  r12, r2, r0
00006825 0 1 0D 00000000 // or    r13, r0, r0
248E8000 0 1 0E 1233D67D // addiu r14, r4, -0x8000
01C17823 0 1 0F FFFF8005 // subu  r15, r14, r1
01E0802A 0 1 10 00000001 // slt   r16, r15, r0
01EF7826 0 1 0F 00000000 // xor   r15, r15, r15
35F1ABCD 0 1 11 0000ABCD // ori   r17, r15, 0xABCD
3C128001 0 1 12 80010000 // lui   r18, 0x8001
02519821 0 1 13 8001ABCD // addu  r19, r18, r17

// ==== testbench/tb_alu_core.sv ====
`timescale 1ns/1ps
`include "core_consts.svh"

module tb_alu_core;
    import core_pkg::*;

    localparam int NUM_VEC     = 24;
    localparam int VEC_WORDS   = 5;
    localparam int HOLD_AT     = 8;
    localparam int TIMEOUT_CYC = 40 * NUM_VEC + 200;

    logic         clk;
    logic         resetn;
    logic         in_valid_i;
    instr_word_u  in_word_i;
    logic         in_credit_o;
    logic         out_valid_o;
    commit_rec_t  out_rec_o;
    logic         out_credit_i;

    logic [31:0]  vec_mem [NUM_VEC*VEC_WORDS];
    int           gap_tbl [NUM_VEC];
    int           ret_tbl [NUM_VEC];
    int           due_q [$];

    logic running;
    logic holding;
    logic hold_done;
    int   cyc;
    int   sender_credits;
    int   credit_pending;
    int   credits_back;
    int   dut_credits;
    int   tx_idx;
    int   rx_cnt;
    int   gap_cnt;
    int   hold_end;
    int   hold_len;
    int   hold_credits;
    int   hold_recs;
    int   error_count;
    int   bp_errors;
    int   tests_run;
    int   tests_passed;
    int   errs_before;

    alu_core_top DUT (
        .clk          (clk),
        .resetn       (resetn),
        .in_valid_i   (in_valid_i),
        .in_word_i    (in_word_i),
        .in_credit_o  (in_credit_o),
        .out_valid_o  (out_valid_o),
        .out_rec_o    (out_rec_o),
        .out_credit_i (out_credit_i)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // compare helpers
    //////////////////////////////////////////////////

    function automatic commit_rec_t expected_rec(input int idx);
        commit_rec_t rec;
        rec.illegal = vec_mem[idx*VEC_WORDS + 1][0];
        rec.wen     = vec_mem[idx*VEC_WORDS + 2][0];
        rec.wnum    = vec_mem[idx*VEC_WORDS + 3][`CORE_REG_AW-1:0];
        rec.wdata   = vec_mem[idx*VEC_WORDS + 4];
        return rec;
    endfunction

    task automatic check_rec(input int idx, input commit_rec_t got, input commit_rec_t exp);
        if (got !== exp) begin
            error_count++;
            $display("Error: out_rec_o record %0d got illegal=%h wen=%h wnum=%h wdata=%h, %s",
                     idx, got.illegal, got.wen, got.wnum, got.wdata, "expected");
            $display("Error: out_rec_o record %0d expected illegal=%h wen=%h wnum=%h wdata=%h",
                     idx, exp.illegal, exp.wen, exp.wnum, exp.wdata);
        end
    endtask

    task automatic check_credits(input string name, input int got, input int exp);
        if (got !== exp) begin
            error_count++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////
    // per-cycle models on the falling edge
    //////////////////////////////////////////////////

    // receiver withholds every credit for one stretch
    task automatic update_hold();
        if (!hold_done && !holding && rx_cnt >= HOLD_AT) begin
            holding      = 1'b1;
            hold_end     = cyc + hold_len;
            hold_credits = dut_credits;
        end else if (holding && cyc >= hold_end) begin
            holding   = 1'b0;
            hold_done = 1'b1;
        end
    endtask

    task automatic watch_commit();
        commit_rec_t exp;
        if (out_valid_o) begin
            if (dut_credits <= 0) begin
                error_count++;
                bp_errors++;
                $display("record %0d was presented while the DUT held no credit", rx_cnt);
            end
            if (holding) begin
                hold_recs++;
            end
            if (rx_cnt >= NUM_VEC) begin
                error_count++;
                $display("a record appeared after all %0d vectors had committed", NUM_VEC);
            end else begin
                errs_before = error_count;
                exp = expected_rec(rx_cnt);
                check_rec(rx_cnt, out_rec_o, exp);
                tests_run++;
                if (error_count == errs_before) begin
                    tests_passed++;
                    $display("test %0d word %h: pass", rx_cnt, vec_mem[rx_cnt*VEC_WORDS]);
                end else begin
                    $display("test %0d word %h: fail", rx_cnt, vec_mem[rx_cnt*VEC_WORDS]);
                end
                due_q.push_back(cyc + 1 + ret_tbl[rx_cnt]);
            end
            rx_cnt++;
            dut_credits--;
        end
    endtask

    task automatic return_credits();
        out_credit_i = 1'b0;
        if (!holding && due_q.size() > 0) begin
            if (due_q[0] <= cyc) begin
                void'(due_q.pop_front());
                out_credit_i = 1'b1;
                dut_credits++;
            end
        end
    endtask

    // a credit seen now is usable once the pop edge has passed
    task automatic drive_sender();
        sender_credits += credit_pending;
        credit_pending = in_credit_o ? 1 : 0;
        if (in_credit_o) begin
            credits_back++;
        end
        in_valid_i = 1'b0;
        if (tx_idx < NUM_VEC) begin
            if (gap_cnt > 0) begin
                gap_cnt--;
            end else if (sender_credits > 0) begin
                in_valid_i = 1'b1;
                in_word_i  = vec_mem[tx_idx*VEC_WORDS];
                sender_credits--;
                tx_idx++;
                if (tx_idx < NUM_VEC) begin
                    gap_cnt = gap_tbl[tx_idx];
                end
            end
        end
    endtask

    always @(negedge clk) begin
        if (running) begin
            cyc++;
            if (cyc > TIMEOUT_CYC) begin
                $display("timeout after %0d cycles with %0d of %0d records seen",
                         cyc, rx_cnt, NUM_VEC);
                $display("CHECKS FAILED");
                $finish;
            end else begin
                update_hold();
                watch_commit();
                return_credits();
                drive_sender();
            end
        end
    end

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(80257));
        resetn         = 1'b0;
        in_valid_i     = 1'b0;
        in_word_i      = '0;
        out_credit_i   = 1'b0;
        running        = 1'b0;
        holding        = 1'b0;
        hold_done      = 1'b0;
        cyc            = 0;
        sender_credits = `CORE_INTAKE_DEPTH;
        credit_pending = 0;
        credits_back   = 0;
        dut_credits    = `CORE_OUT_CREDITS;
        tx_idx         = 0;
        rx_cnt         = 0;
        hold_recs      = 0;
        hold_credits   = 0;
        hold_end       = 0;
        error_count    = 0;
        bp_errors      = 0;
        tests_run      = 0;
        tests_passed   = 0;
        $readmemh("testbench/alu_core_vectors.txt", vec_mem);
        for (int i = 0; i < NUM_VEC; i++) begin
            gap_tbl[i] = $urandom % 3;
            ret_tbl[i] = $urandom % 4;
        end
        hold_len = 30 + ($urandom % 40);
        gap_cnt  = gap_tbl[0];

        repeat (16) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        @(posedge clk);

        if ($isunknown(vec_mem[NUM_VEC*VEC_WORDS-1])) begin
            $display("the vector file is missing or holds fewer than %0d vectors", NUM_VEC);
            $display("CHECKS FAILED");
            $finish;
        end else begin
            running = 1'b1;
            while (rx_cnt < NUM_VEC || due_q.size() != 0 ||
                   sender_credits != `CORE_INTAKE_DEPTH) begin
                @(negedge clk);
            end
            // quiet period so a stray record would still be caught
            repeat (20) @(negedge clk);
            @(posedge clk);

            tests_run++;
            if (!hold_done) begin
                error_count++;
                $display("the receiver credit hold never ran to its end");
            end else if (hold_recs > hold_credits) begin
                error_count++;
                $display("%0d records appeared during the hold with only %0d credits granted",
                         hold_recs, hold_credits);
            end
            if (hold_done && bp_errors == 0 && hold_recs <= hold_credits) begin
                tests_passed++;
                $display("test backpressure held %0d cycles, %0d records: pass",
                         hold_len, hold_recs);
            end else begin
                $display("test backpressure: fail");
            end

            tests_run++;
            errs_before = error_count;
            check_credits("sender credits", sender_credits, `CORE_INTAKE_DEPTH);
            check_credits("in_credit_o pulses", credits_back, NUM_VEC);
            check_credits("out_valid_o records", rx_cnt, NUM_VEC);
            if (error_count == errs_before) begin
                tests_passed++;
                $display("test credit balance: pass");
            end else begin
                $display("test credit balance: fail");
            end

            $display("%0d tests, %0d passed, %0d failed, %0d errors",
                     tests_run, tests_passed, tests_run - tests_passed, error_count);
            if (error_count == 0) begin
                $display("ALL CHECKS PASSED");
            end else begin
                $display("CHECKS FAILED");
            end
            $finish;
        end
    end

endmodule
